// ==== sources.f ====
+incdir+hdl
hdl/repeater_pkg.sv
hdl/latching_skid_buffer.sv
hdl/sync_pulse_timer.sv
hdl/sync_repeater.sv
hdl/repeater_subsystem.sv
dv/repeater_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the repeater testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module repeater_tb -f sources.f -o repeater_sim

# The simulator exits non-zero on $fatal, tee keeps the log for the check below
./obj_dir/repeater_sim 2>&1 | tee "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// ==== dv/repeater_tb.sv ====
/*
  Sample repeater testbench
  Streams words into the repeater subsystem, applies back-pressure with
  out_ready and sweeps the sync period. A cycle model of the buffer,
  the repeater and the timer feeds concurrent assertions
*/

`default_nettype none

`include "repeater_params.svh"

module repeater_tb
    import repeater_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clock_period = 8;
    localparam int reset_cycles = 16;
    localparam int idle_cycles = 40;
    localparam int tick_period = 10;
    // Ticks spent in the streaming and back-pressure phases
    localparam int stream_ticks = 14;
    localparam int pressure_ticks = 12;
    localparam int spacing_cycles = 200;
    localparam int margin_cycles = 200;
    localparam int watchdog_cycles = reset_cycles + idle_cycles
        + (stream_ticks + pressure_ticks) * tick_period + spacing_cycles + margin_cycles;

    // One word packed as data, dest, user, last
    typedef logic [`REPEATER_DATA_WIDTH + `REPEATER_DEST_WIDTH + `REPEATER_USER_WIDTH:0] word_t;

    logic clock;
    logic reset;
    data_word_t in_data;
    dest_word_t in_dest;
    user_word_t in_user;
    logic in_last;
    logic in_valid;
    wire in_ready;
    wire data_word_t out_data;
    wire dest_word_t out_dest;
    wire user_word_t out_user;
    wire out_last;
    wire out_valid;
    logic out_ready;
    logic sync_enable;
    sync_period_t sync_period;
    wire sync_tick;

    integer seed;

    // Model of the buffer contents with the oldest word first
    word_t pending[$];
    // Word left in the head registers after it was consumed
    word_t latched;
    bit timer_running;
    int ticks_left;

    // Expected values updated on the clock edge alongside the DUT
    int model_count;
    logic model_primed;
    logic expected_strobe;
    word_t expected_out;
    logic expected_tick;

    repeater_subsystem uut (
        .clock(clock),
        .reset(reset),
        .in_data(in_data),
        .in_dest(in_dest),
        .in_user(in_user),
        .in_last(in_last),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_dest(out_dest),
        .out_user(out_user),
        .out_last(out_last),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .sync_enable(sync_enable),
        .sync_period(sync_period),
        .sync_tick(sync_tick)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    // Periods below the minimum run at the minimum
    function automatic int effective_period(input sync_period_t period);
        return (int'(period) < `SYNC_PERIOD_MIN) ? `SYNC_PERIOD_MIN : int'(period);
    endfunction

    function automatic word_t random_word();
        return {data_word_t'($random(seed)), dest_word_t'($random(seed)),
                user_word_t'($random(seed)), 1'($random(seed))};
    endfunction

    // Called on a falling edge and holds the word until in_ready lets it through
    task automatic send_word(input word_t word);
        {in_data, in_dest, in_user, in_last} = word;
        in_valid = 1'b1;
        while (!in_ready) begin
            @(negedge clock);
        end
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    // Returns on the falling edge of a tick cycle
    task automatic wait_for_tick();
        do begin
            @(negedge clock);
        end while (!sync_tick);
    endtask

    // Lets exactly one head word leave the buffer
    task automatic pulse_out_ready();
        out_ready = 1'b1;
        @(negedge clock);
        out_ready = 1'b0;
    endtask

    task automatic run_period(input int period, input int cycles);
        sync_enable = 1'b0;
        repeat (4) @(negedge clock);
        sync_period = sync_period_t'(period);
        sync_enable = 1'b1;
        repeat (cycles) @(negedge clock);
    endtask

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Buffer and repeater model working on the values present before the edge
    always @(posedge clock) begin
        word_t head;
        if (!reset) begin
            pending.delete();
            model_count <= 0;
            model_primed <= 1'b0;
            expected_strobe <= 1'b0;
            expected_out <= '0;
        end else begin
            head = (pending.size() != 0) ? pending[0] : latched;
            // A tick seen while primed turns into a strobe of the current head
            expected_strobe <= sync_tick && model_primed;
            if (sync_tick && model_primed) begin
                expected_out <= head;
            end
            if (pending.size() != 0) begin
                model_primed <= 1'b1;
            end
            // The head leaves first, so a word arriving on the same edge lands behind it
            if (pending.size() != 0 && out_ready) begin
                latched = pending.pop_front();
            end
            if (in_valid && in_ready) begin
                pending.push_back({in_data, in_dest, in_user, in_last});
            end
            model_count <= pending.size();
        end
    end

    // Timer model with the first tick one period after enable is seen high
    always @(posedge clock) begin
        expected_tick <= 1'b0;
        if (!reset || !sync_enable) begin
            timer_running = 1'b0;
        end else if (!timer_running) begin
            timer_running = 1'b1;
            ticks_left = effective_period(sync_period);
        end else begin
            ticks_left = ticks_left - 1;
            if (ticks_left == 0) begin
                expected_tick <= 1'b1;
                // The period in force at expiry sets the next interval
                ticks_left = effective_period(sync_period);
            end
        end
    end

    in_ready_check: assert property (@(posedge clock) disable iff (!reset)
        in_ready == (model_count < 2))
        else stop_with_failure($sformatf("MISMATCH at %0d ns: in_ready is %b with %0d words held",
            $time, $sampled(in_ready), $sampled(model_count)));

    tick_check: assert property (@(posedge clock) disable iff (!reset)
        sync_tick == expected_tick)
        else stop_with_failure($sformatf("MISMATCH at %0d ns: sync_tick is %b, expected %b",
            $time, $sampled(sync_tick), $sampled(expected_tick)));

    tick_width_check: assert property (@(posedge clock) disable iff (!reset)
        sync_tick |=> !sync_tick)
        else stop_with_failure($sformatf("MISMATCH at %0d ns: sync_tick high for two cycles",
            $time));

    strobe_timing_check: assert property (@(posedge clock) disable iff (!reset)
        out_valid == expected_strobe)
        else stop_with_failure($sformatf("MISMATCH at %0d ns: out_valid is %b, expected %b",
            $time, $sampled(out_valid), $sampled(expected_strobe)));

    unprimed_check: assert property (@(posedge clock) disable iff (!reset)
        !model_primed |-> (!out_valid && {out_data, out_dest, out_user, out_last} == '0))
        else stop_with_failure($sformatf("MISMATCH at %0d ns: output active before first word",
            $time));

    payload_check: assert property (@(posedge clock) disable iff (!reset)
        out_valid |-> ({out_data, out_dest, out_user, out_last} == expected_out))
        else stop_with_failure($sformatf("MISMATCH at %0d ns: strobe carries %h, expected %h",
            $time, $sampled({out_data, out_dest, out_user, out_last}), $sampled(expected_out)));

    initial begin
        #(watchdog_cycles * clock_period);
        stop_with_failure("Timeout: the tests did not finish in the expected time");
    end

    initial begin
        seed = 60788;
        reset = 1'b0;
        in_data = '0;
        in_dest = '0;
        in_user = '0;
        in_last = 1'b0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        sync_enable = 1'b0;
        sync_period = sync_period_t'(tick_period);
        repeat (reset_cycles) @(negedge clock);
        reset = 1'b1;

        // Ticks run but nothing has arrived yet, so no strobe may appear
        sync_enable = 1'b1;
        repeat (idle_cycles) @(negedge clock);

        // Single words each written a few cycles after a tick
        repeat (6) begin
            wait_for_tick();
            repeat (2) @(negedge clock);
            send_word(random_word());
        end
        wait_for_tick();
        repeat (3) @(negedge clock);
        send_word(random_word());
        send_word(random_word());
        // The last word keeps repeating once it has been consumed
        repeat (3) wait_for_tick();

        // Back-pressure fills both entries and stalls the producer
        wait_for_tick();
        out_ready = 1'b0;
        repeat (2) @(negedge clock);
        send_word(random_word());
        send_word(random_word());
        repeat (3) wait_for_tick();
        fork
            send_word(random_word());
            begin
                repeat (4) begin
                    wait_for_tick();
                    pulse_out_ready();
                end
            end
        join
        out_ready = 1'b1;
        repeat (3) wait_for_tick();

        // Tick spacing across periods including one below the minimum
        run_period(1, 11);
        run_period(2, 11);
        run_period(5, 23);
        run_period(13, 20);
        sync_period = sync_period_t'(5);
        repeat (30) @(negedge clock);
        sync_enable = 1'b0;
        repeat (20) @(negedge clock);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/repeater_subsystem.sv ====
/*
  Sample repeater subsystem
  Top level of the repeater. Input words are registered in the latching
  skid buffer and the repeater sends the buffer head downstream on each
  tick of the programmable sync timer
*/

`default_nettype none

`include "repeater_params.svh"

module repeater_subsystem
    import repeater_pkg::*;
#(
    parameter bit hold_valid = 1'b1
) (
    input  wire          clock,
    input  wire          reset,
    input  wire data_word_t in_data,
    input  wire dest_word_t in_dest,
    input  wire user_word_t in_user,
    input  wire          in_last,
    input  wire          in_valid,
    output wire          in_ready,
    output wire data_word_t out_data,
    output wire dest_word_t out_dest,
    output wire user_word_t out_user,
    output wire          out_last,
    output wire          out_valid,
    input  wire          out_ready,
    input  wire          sync_enable,
    input  wire sync_period_t sync_period,
    output wire          sync_tick
);

    // Buffer head as seen by the repeater
    wire data_word_t head_data;
    wire dest_word_t head_dest;
    wire user_word_t head_user;
    wire head_last;
    wire head_valid;
    wire head_ready;

    latching_skid_buffer buffer (
        .clock(clock),
        .reset(reset),
        .in_data(in_data),
        .in_dest(in_dest),
        .in_user(in_user),
        .in_last(in_last),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .head_data(head_data),
        .head_dest(head_dest),
        .head_user(head_user),
        .head_last(head_last),
        .head_valid(head_valid),
        .head_ready(head_ready)
    );

    // The tick is also brought out so downstream logic can align to the loop
    sync_pulse_timer timer (
        .clock(clock),
        .reset(reset),
        .enable(sync_enable),
        .period(sync_period),
        .tick(sync_tick)
    );

    sync_repeater #(
        .hold_valid(hold_valid)
    ) repeater (
        .clock(clock),
        .reset(reset),
        .sync(sync_tick),
        .head_data(head_data),
        .head_dest(head_dest),
        .head_user(head_user),
        .head_last(head_last),
        .head_valid(head_valid),
        .head_ready(head_ready),
        .out_data(out_data),
        .out_dest(out_dest),
        .out_user(out_user),
        .out_last(out_last),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

`default_nettype wire

// ==== hdl/sync_repeater.sv ====
/*
  Sync repeater
  Waits for the first word from the skid buffer, then on every sync tick
  copies the buffer head to the outputs and sends it as a one-cycle
  strobe. The output carries no handshake of its own
*/

`default_nettype none

`include "repeater_params.svh"

module sync_repeater
    import repeater_pkg::*;
#(
    // When set, every strobe is marked valid, otherwise it follows head_valid
    parameter bit hold_valid = 1'b1
) (
    input  wire        clock,
    input  wire        reset,
    input  wire        sync,
    input  wire data_word_t head_data,
    input  wire dest_word_t head_dest,
    input  wire user_word_t head_user,
    input  wire        head_last,
    input  wire        head_valid,
    output logic       head_ready,
    output data_word_t out_data,
    output dest_word_t out_dest,
    output user_word_t out_user,
    output logic       out_last,
    output logic       out_valid,
    input  wire        out_ready
);

    // Set once the buffer has shown a word, stays set until reset
    logic primed;

    // Downstream ready only paces the buffer
    assign head_ready = out_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            primed <= 1'b0;
        end else if (head_valid) begin
            primed <= 1'b1;
        end
    end

    // out_valid defaults low so that each tick yields a single-cycle strobe
    always_ff @(posedge clock) begin
        if (!reset) begin
            out_data <= '0;
            out_dest <= '0;
            out_user <= '0;
            out_last <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (sync && primed) begin
                // Sample the head, which may be the latched word already consumed
                out_data <= head_data;
                out_dest <= head_dest;
                out_user <= head_user;
                out_last <= head_last;
                if (hold_valid) begin
                    out_valid <= 1'b1;
                end else begin
                    out_valid <= head_valid;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sync_pulse_timer.sv ====
/*
  Sync pulse timer
  Down-counter that produces a registered one-cycle tick every period
  cycles while enabled. Periods below the minimum are clamped up
*/

`default_nettype none

`include "repeater_params.svh"

module sync_pulse_timer
    import repeater_pkg::*;
(
    input  wire          clock,
    input  wire          reset,
    input  wire          enable,
    input  wire sync_period_t period,
    output logic         tick
);

    sync_period_t count;
    sync_period_t reload_value;

    // Effective period, never shorter than the minimum
    assign reload_value = (period < sync_period_t'(`SYNC_PERIOD_MIN))
        ? sync_period_t'(`SYNC_PERIOD_MIN) : period;

    // A count of zero means idle, the counter expires when it reaches one
    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
            tick <= 1'b0;
        end else if (!enable) begin
            count <= '0;
            tick <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (count == '0) begin
                // Just enabled, start the first period
                count <= reload_value;
            end else if (count == sync_period_t'(1)) begin
                // Period done, pulse and pick up the current setting
                tick <= 1'b1;
                count <= reload_value;
            end else begin
                count <= count - sync_period_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/latching_skid_buffer.sv ====
/*
  Latching skid buffer
  Two-entry registered buffer between the producer and the repeater.
  in_ready comes straight from a flop, and the output payload registers
  keep the last word after it has been consumed, so the repeater can
  keep sending it
*/

`default_nettype none

`include "repeater_params.svh"

module latching_skid_buffer
    import repeater_pkg::*;
(
    input  wire        clock,
    input  wire        reset,
    input  wire data_word_t in_data,
    input  wire dest_word_t in_dest,
    input  wire user_word_t in_user,
    input  wire        in_last,
    input  wire        in_valid,
    output logic       in_ready,
    output data_word_t head_data,
    output dest_word_t head_dest,
    output user_word_t head_user,
    output logic       head_last,
    output logic       head_valid,
    input  wire        head_ready
);

    buffer_state_t state;
    buffer_state_t next_state;

    // Second entry, only used while the head is stalled
    data_word_t skid_data;
    dest_word_t skid_dest;
    user_word_t skid_user;
    logic       skid_last;

    logic in_transfer;
    logic head_transfer;
    logic load_head;
    logic load_skid;
    logic head_from_skid;

    assign in_transfer = in_valid & in_ready;
    assign head_transfer = head_valid & head_ready;

    // Head is valid whenever the output register holds an unconsumed word
    assign head_valid = (state != buffer_empty);

    always_comb begin
        next_state = state;
        load_head = 1'b0;
        load_skid = 1'b0;
        head_from_skid = 1'b0;
        case (state)
            buffer_empty: begin
                if (in_transfer) begin
                    next_state = buffer_holding;
                    load_head = 1'b1;
                end
            end
            buffer_holding: begin
                // A word arriving while the head leaves goes straight to the head
                if (in_transfer && head_transfer) begin
                    load_head = 1'b1;
                end else if (in_transfer) begin
                    next_state = buffer_full;
                    load_skid = 1'b1;
                end else if (head_transfer) begin
                    next_state = buffer_empty;
                end
            end
            buffer_full: begin
                // in_ready is low here, so only the head can move
                if (head_transfer) begin
                    next_state = buffer_holding;
                    head_from_skid = 1'b1;
                end
            end
            default: begin
                next_state = buffer_empty;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= buffer_empty;
            in_ready <= 1'b1;
        end else begin
            state <= next_state;
            // Registered ready, low only while both entries are taken
            in_ready <= (next_state != buffer_full);
        end
    end

    // Head registers change only on a load, which gives the latching behaviour
    always_ff @(posedge clock) begin
        if (load_head) begin
            head_data <= in_data;
            head_dest <= in_dest;
            head_user <= in_user;
            head_last <= in_last;
        end else if (head_from_skid) begin
            head_data <= skid_data;
            head_dest <= skid_dest;
            head_user <= skid_user;
            head_last <= skid_last;
        end
        if (load_skid) begin
            skid_data <= in_data;
            skid_dest <= in_dest;
            skid_user <= in_user;
            skid_last <= in_last;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/repeater_pkg.sv ====
/*
  Sample repeater package
  Vector types for the word fields and the sync period, and the state
  encoding of the latching skid buffer
*/

`default_nettype none

`include "repeater_params.svh"

package repeater_pkg;

    // Payload and side fields of one word
    typedef logic [`REPEATER_DATA_WIDTH-1:0] data_word_t;
    typedef logic [`REPEATER_DEST_WIDTH-1:0] dest_word_t;
    typedef logic [`REPEATER_USER_WIDTH-1:0] user_word_t;

    // Sync period setting and the timer down-counter share this type
    typedef logic [`SYNC_PERIOD_WIDTH-1:0] sync_period_t;

    // Occupancy of the skid buffer
    // Holding means only the output register is valid, full means the
    // skid register is in use as well
    typedef enum logic [1:0] {
        buffer_empty,
        buffer_holding,
        buffer_full
    } buffer_state_t;

endpackage

`default_nettype wire

// ==== hdl/repeater_params.svh ====
/*
  Sample repeater parameters
  Field widths of the repeated word and the limits of the sync period
  setting shared by the timer, the skid buffer and the repeater
*/

`ifndef REPEATER_PARAMS_SVH
`define REPEATER_PARAMS_SVH

// Width of the payload carried by each word
`define REPEATER_DATA_WIDTH 32

// Destination and user side fields travel with the payload
`define REPEATER_DEST_WIDTH 8
`define REPEATER_USER_WIDTH 8

// Width of the programmable sync period, counted in clock cycles
`define SYNC_PERIOD_WIDTH 16

// Shortest period the timer will run at
// Smaller settings are clamped up to this value
`define SYNC_PERIOD_MIN 2

`endif
